// ==== hdl/up_pkg.sv ====
package up_pkg;

   // Instruction nibbles
   localparam logic [3:0] OPC_OUT   = 4'h0;
   localparam logic [3:0] OPC_ADD   = 4'h1;
   localparam logic [3:0] OPC_SUB   = 4'h2;
   localparam logic [3:0] OPC_MUL   = 4'h3;
   localparam logic [3:0] OPC_DIV   = 4'h4;
   localparam logic [3:0] OPC_NAND  = 4'h5;
   localparam logic [3:0] OPC_MV01  = 4'h6;
   localparam logic [3:0] OPC_MV12  = 4'h7;
   localparam logic [3:0] OPC_MV23  = 4'h8;
   localparam logic [3:0] OPC_LIT1  = 4'h9;
   localparam logic [3:0] OPC_LIT2  = 4'hA;
   localparam logic [3:0] OPC_LIT3  = 4'hB;
   localparam logic [3:0] OPC_JMP   = 4'hC;
   localparam logic [3:0] OPC_SPINC = 4'hD;
   localparam logic [3:0] OPC_SPDEC = 4'hE;
   localparam logic [3:0] OPC_HALT  = 4'hF;

   // Datapath bus ops
   localparam logic [4:0] BUS_ADD   = 5'b00000;
   localparam logic [4:0] BUS_SUB   = 5'b00001;
   localparam logic [4:0] BUS_MUL   = 5'b00010;
   localparam logic [4:0] BUS_DIV   = 5'b00011;
   localparam logic [4:0] BUS_NAND  = 5'b00100;
   localparam logic [4:0] BUS_X01   = 5'b00101;
   localparam logic [4:0] BUS_X12   = 5'b00110;
   localparam logic [4:0] BUS_X23   = 5'b00111;
   localparam logic [4:0] BUS_XSP   = 5'b01000;
   localparam logic [4:0] BUS_XPC   = 5'b01001;
   localparam logic [4:0] BUS_SPINC = 5'b01010;
   localparam logic [4:0] BUS_SPDEC = 5'b01011;
   localparam logic [4:0] BUS_PC    = 5'b01100;
   localparam logic [4:0] BUS_PADDR = 5'b01101;  // Program byte pc/2
   localparam logic [4:0] BUS_LADDR = 5'b01110;  // Literal byte pc/2 | 0x80
   localparam logic [4:0] BUS_PCINC = 5'b01111;
   localparam logic [4:0] BUS_DIN   = 5'b10000;

   // Register bank write selects
   localparam logic [2:0] SEL_I0 = 3'b000;
   localparam logic [2:0] SEL_I1 = 3'b001;
   localparam logic [2:0] SEL_I2 = 3'b010;
   localparam logic [2:0] SEL_I3 = 3'b011;
   localparam logic [2:0] SEL_O0 = 3'b100;
   localparam logic [2:0] SEL_O1 = 3'b101;
   localparam logic [2:0] SEL_O2 = 3'b110;
   localparam logic [2:0] SEL_O3 = 3'b111;

   localparam int MEM_AW    = 8;
   localparam int MEM_DEPTH = 256;

   localparam logic [7:0] RST_PC = 8'h00;
   localparam logic [7:0] RST_SP = 8'hFF;
   localparam logic [7:0] RST_R0 = 8'h01;
   localparam logic [7:0] RST_R1 = 8'h02;
   localparam logic [7:0] RST_R2 = 8'h03;
   localparam logic [7:0] RST_R3 = 8'h04;

   // Control FSM states
   localparam logic [2:0] ST_IDLE   = 3'd0;
   localparam logic [2:0] ST_FETCH  = 3'd1;
   localparam logic [2:0] ST_DECODE = 3'd2;
   localparam logic [2:0] ST_EXEC   = 3'd3;
   localparam logic [2:0] ST_LOAD   = 3'd4;
   localparam logic [2:0] ST_NEXT   = 3'd5;
   localparam logic [2:0] ST_HALTED = 3'd6;

endpackage

// ==== hdl/up_datapath.sv ====
module up_datapath (
   input  logic       clk,
   input  logic       nRst,
   input  logic [7:0] data_in,
   input  logic [4:0] op,
   input  logic       ir_we,
   input  logic       pc_we,
   input  logic       sp_we,
   input  logic       rb_we,
   input  logic [2:0] rb_sel,
   output logic [7:0] data_out,
   output logic [3:0] ir,
   output logic       pc_lsb
);
   import up_pkg::*;

   logic [7:0] pc;
   logic [7:0] sp;
   logic [7:0] r0;
   logic [7:0] r1;
   logic [7:0] r2;
   logic [7:0] r3;

   assign pc_lsb = pc[0];

   always_comb begin
      case (op)
         BUS_ADD:   data_out = r1 + r2;
         BUS_SUB:   data_out = r1 - r2;
         BUS_MUL:   data_out = r1 * r2;     // Low byte of the product
         BUS_DIV:   data_out = (r2 == 8'h00) ? 8'hFF : r1 / r2;
         BUS_NAND:  data_out = ~(r1 & r2);
         BUS_X01:   data_out = r0 ^ r1;
         BUS_X12:   data_out = r1 ^ r2;
         BUS_X23:   data_out = r2 ^ r3;
         BUS_XSP:   data_out = sp ^ r3;
         BUS_XPC:   data_out = pc ^ r3;
         BUS_SPINC: data_out = sp + 8'h01;
         BUS_SPDEC: data_out = sp - 8'h01;
         BUS_PC:    data_out = pc;
         BUS_PADDR: data_out = {1'b0, pc[7:1]};
         BUS_LADDR: data_out = {1'b1, pc[7:1]};
         BUS_PCINC: data_out = pc + 8'h01;
         default:   data_out = data_in;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= RST_PC;
         sp <= RST_SP;
         ir <= 4'h0;
         r0 <= RST_R0;
         r1 <= RST_R1;
         r2 <= RST_R2;
         r3 <= RST_R3;
      end else begin
         if (ir_we) begin
            ir <= pc[0] ? data_out[7:4] : data_out[3:0];  // Nibble by pc bit 0
         end
         if (pc_we) begin
            pc <= data_out;
         end
         if (sp_we) begin
            sp <= data_out;
         end
         if (rb_we) begin
            case (rb_sel)
               SEL_I0:  r0 <= data_in;
               SEL_I1:  r1 <= data_in;
               SEL_I2:  r2 <= data_in;
               SEL_I3:  r3 <= data_in;
               SEL_O0:  r0 <= data_out;
               SEL_O1:  r1 <= data_out;
               SEL_O2:  r2 <= data_out;
               default: r3 <= data_out;
            endcase
         end
      end
   end

endmodule

// ==== hdl/up_control.sv ====
module up_control (
   input  logic       clk,
   input  logic       nRst,
   input  logic       run,
   input  logic [3:0] ir,
   input  logic       pc_lsb,
   output logic [4:0] op,
   output logic       ir_we,
   output logic       pc_we,
   output logic       sp_we,
   output logic       rb_we,
   output logic [2:0] rb_sel,
   output logic       out_valid,
   output logic       halted
);
   import up_pkg::*;

   logic [2:0] state;
   logic [2:0] state_nxt;
   logic       is_lit;
   logic       is_jmp;

   assign is_lit = (ir == OPC_LIT1) || (ir == OPC_LIT2) || (ir == OPC_LIT3);
   assign is_jmp = (ir == OPC_JMP);
   assign halted = (state == ST_HALTED);

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (run)
               state_nxt = ST_FETCH;
         end
         ST_FETCH:  state_nxt = ST_DECODE;
         ST_DECODE: state_nxt = ST_EXEC;
         ST_EXEC: begin
            if (ir == OPC_HALT)
               state_nxt = ST_HALTED;
            else if (is_lit || is_jmp)
               state_nxt = ST_LOAD;   // Literal byte arrives next cycle
            else
               state_nxt = ST_NEXT;
         end
         ST_LOAD: begin
            if (is_jmp)
               state_nxt = run ? ST_FETCH : ST_IDLE;
            else
               state_nxt = ST_NEXT;
         end
         ST_NEXT:   state_nxt = run ? ST_FETCH : ST_IDLE;
         ST_HALTED: state_nxt = ST_HALTED;
         default:   state_nxt = ST_IDLE;
      endcase
   end

   always_comb begin
      op        = BUS_DIN;
      ir_we     = 1'b0;
      pc_we     = 1'b0;
      sp_we     = 1'b0;
      rb_we     = 1'b0;
      rb_sel    = SEL_O0;
      out_valid = 1'b0;
      case (state)
         ST_FETCH: begin
            op = BUS_PADDR;   // Byte pc/2 holds both nibbles
         end
         ST_DECODE: begin
            ir_we = 1'b1;
         end
         ST_EXEC: begin
            case (ir)
               OPC_OUT: begin
                  op        = BUS_XSP;
                  out_valid = 1'b1;
               end
               OPC_ADD, OPC_SUB, OPC_MUL, OPC_DIV, OPC_NAND: begin
                  op    = {1'b0, ir - 4'h1};  // ALU ops are ordered like opcodes
                  rb_we = 1'b1;
               end
               OPC_MV01: begin
                  op     = BUS_X01;
                  rb_we  = 1'b1;
                  rb_sel = SEL_O1;
               end
               OPC_MV12: begin
                  op     = BUS_X12;
                  rb_we  = 1'b1;
                  rb_sel = SEL_O2;
               end
               OPC_MV23: begin
                  op     = BUS_X23;
                  rb_we  = 1'b1;
                  rb_sel = SEL_O3;
               end
               OPC_LIT1, OPC_LIT2, OPC_LIT3, OPC_JMP: begin
                  op = BUS_LADDR;
               end
               OPC_SPINC: begin
                  op    = BUS_SPINC;
                  sp_we = 1'b1;
               end
               OPC_SPDEC: begin
                  op    = BUS_SPDEC;
                  sp_we = 1'b1;
               end
               default: begin
                  op = BUS_DIN;   // HALT
               end
            endcase
         end
         ST_LOAD: begin
            if (is_jmp) begin
               pc_we = 1'b1;
            end else begin
               rb_we  = 1'b1;
               rb_sel = {1'b0, ir[1:0]};  // LIT1..3 to SEL_I1..3
            end
         end
         ST_NEXT: begin
            op    = BUS_PCINC;
            pc_we = 1'b1;
         end
         default: begin
            op = BUS_DIN;
         end
      endcase
   end

endmodule

// ==== hdl/up_memory.sv ====
module up_memory (
   input  logic                      clk,
   input  logic                      load_we,
   input  logic [up_pkg::MEM_AW-1:0] load_addr,
   input  logic [7:0]                load_data,
   input  logic [up_pkg::MEM_AW-1:0] addr,
   output logic [7:0]                rdata
);
   import up_pkg::*;

   // Program in 0x00-0x7F, literals in 0x80-0xFF
   logic [7:0] mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (load_we) begin
         mem[load_addr] <= load_data;
      end
   end

   // Read follows the bus address every cycle
   always_ff @(posedge clk) begin
      rdata <= mem[addr];
   end

endmodule

// ==== hdl/up_top.sv ====
module up_top (
   input  logic                      clk,
   input  logic                      nRst,
   input  logic                      run,
   input  logic                      load_we,
   input  logic [up_pkg::MEM_AW-1:0] load_addr,
   input  logic [7:0]                load_data,
   output logic [7:0]                out_data,
   output logic                      out_valid,
   output logic                      halted
);

   logic [7:0] bus;       // Address and write-back bus
   logic [7:0] rdata;
   logic [4:0] op;
   logic [3:0] ir;
   logic       pc_lsb;
   logic       ir_we;
   logic       pc_we;
   logic       sp_we;
   logic       rb_we;
   logic [2:0] rb_sel;

   assign out_data = bus;   // sp ^ r3 while OUT executes

   up_datapath u_datapath (
      .clk      (clk),
      .nRst     (nRst),
      .data_in  (rdata),
      .op       (op),
      .ir_we    (ir_we),
      .pc_we    (pc_we),
      .sp_we    (sp_we),
      .rb_we    (rb_we),
      .rb_sel   (rb_sel),
      .data_out (bus),
      .ir       (ir),
      .pc_lsb   (pc_lsb)
   );

   up_control u_control (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .ir        (ir),
      .pc_lsb    (pc_lsb),
      .op        (op),
      .ir_we     (ir_we),
      .pc_we     (pc_we),
      .sp_we     (sp_we),
      .rb_we     (rb_we),
      .rb_sel    (rb_sel),
      .out_valid (out_valid),
      .halted    (halted)
   );

   up_memory u_memory (
      .clk       (clk),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .addr      (bus),
      .rdata     (rdata)
   );

endmodule

// ==== tb/up_tb_model.svh ====
`ifndef UP_TB_MODEL_SVH
`define UP_TB_MODEL_SVH

logic [7:0]  image [256];   // Byte image written through the load port
logic [7:0]  exp_q [$];     // Predicted out_data values, oldest first
int          bld_pc;        // Next free nibble address
int          last_lit_byte;
logic [31:0] rnd;

function automatic void clear_image();
   for (int a = 0; a < 256; a++) begin
      image[a] = 8'(a * 7) ^ 8'h5A;
   end
   bld_pc        = 0;
   last_lit_byte = -1;
endfunction

function automatic void put_nibble(input int pc, input logic [3:0] opc);
   if (pc % 2 == 1)
      image[pc / 2][7:4] = opc;
   else
      image[pc / 2][3:0] = opc;
endfunction

function automatic void emit(input logic [3:0] opc);
   put_nibble(bld_pc, opc);
   bld_pc++;
endfunction

function automatic void emit_lit(input logic [3:0] opc, input logic [7:0] value);
   if (bld_pc / 2 == last_lit_byte)
      emit(OPC_MV23);   // Both nibbles of a byte share one literal
   image[128 + bld_pc / 2] = value;
   last_lit_byte           = bld_pc / 2;
   emit(opc);
endfunction

// r0 walks through r1, r2 and r3 to the output
function automatic void emit_show_r0();
   emit(OPC_MV01);
   emit(OPC_MV12);
   emit(OPC_MV23);
   emit(OPC_OUT);
endfunction

task automatic build_alu();
   logic [3:0] alu_op [5];
   alu_op = '{OPC_ADD, OPC_SUB, OPC_MUL, OPC_DIV, OPC_NAND};
   clear_image();
   emit(OPC_MV01);   // r1 = 1 ^ 2, now equal to r2
   emit(OPC_MV12);   // r2 = 0
   emit(OPC_DIV);
   emit_show_r0();
   for (int i = 0; i < 5; i++) begin
      rnd = $urandom;
      emit_lit(OPC_LIT1, rnd[7:0]);
      emit_lit(OPC_LIT2, rnd[15:8]);
      emit_lit(OPC_LIT3, rnd[23:16]);
      emit(alu_op[i]);
      emit_show_r0();
   end
   emit(OPC_HALT);
endtask

task automatic build_jmp();
   clear_image();
   put_nibble(0, OPC_JMP);   // Low nibble, odd target
   image[8'h80] = 8'h05;
   for (int pc = 1; pc < 5; pc++)
      put_nibble(pc, OPC_OUT);
   put_nibble(5, OPC_SPINC);
   put_nibble(6, OPC_OUT);
   put_nibble(7, OPC_JMP);   // High nibble, even target
   image[8'h83] = 8'h0C;
   for (int pc = 8; pc < 12; pc++)
      put_nibble(pc, OPC_OUT);
   put_nibble(12, OPC_SPDEC);
   put_nibble(13, OPC_OUT);
   put_nibble(14, OPC_HALT);
endtask

// Interprets the image from the reset state and queues every output
task automatic run_model(output int n_exec, output logic done);
   logic [7:0] pc;
   logic [7:0] next_pc;
   logic [7:0] sp;
   logic [7:0] r [4];
   logic [7:0] lit;
   logic [7:0] prog_byte;
   logic [3:0] opc;
   pc     = 8'h00;
   sp     = 8'hFF;
   r      = '{8'h01, 8'h02, 8'h03, 8'h04};
   n_exec = 0;
   done   = 1'b0;
   exp_q.delete();
   while (!done && n_exec < 256) begin
      prog_byte = image[{1'b0, pc[7:1]}];
      lit       = image[{1'b1, pc[7:1]}];
      opc       = pc[0] ? prog_byte[7:4] : prog_byte[3:0];
      next_pc   = pc + 8'h01;
      n_exec++;
      case (opc)
         OPC_OUT:   exp_q.push_back(sp ^ r[3]);
         OPC_ADD:   r[0] = r[1] + r[2];
         OPC_SUB:   r[0] = r[1] - r[2];
         OPC_MUL:   r[0] = r[1] * r[2];
         OPC_DIV:   r[0] = (r[2] == 8'h00) ? 8'hFF : r[1] / r[2];
         OPC_NAND:  r[0] = ~(r[1] & r[2]);
         OPC_MV01:  r[1] = r[0] ^ r[1];
         OPC_MV12:  r[2] = r[1] ^ r[2];
         OPC_MV23:  r[3] = r[2] ^ r[3];
         OPC_LIT1:  r[1] = lit;
         OPC_LIT2:  r[2] = lit;
         OPC_LIT3:  r[3] = lit;
         OPC_JMP:   next_pc = lit;
         OPC_SPINC: sp = sp + 8'h01;
         OPC_SPDEC: sp = sp - 8'h01;
         default:   done = 1'b1;
      endcase
      pc = next_pc;
   end
endtask

`endif

// ==== tb/tb_up_top.sv ====
module tb_up_top;
   timeunit 1ns;
   timeprecision 1ps;
   import up_pkg::*;

   logic       clk;
   logic       nRst;
   logic       run;
   logic       load_we;
   logic [7:0] load_addr;
   logic [7:0] load_data;
   logic [7:0] out_data;
   logic       out_valid;
   logic       halted;

   int         test_errors;
   int         pass_count;
   int         fail_count;
   int         cycle_count;
   int         cycle_limit;
   logic [7:0] exp_val;
   logic       have_exp;

   `include "up_tb_model.svh"

   up_top u_dut (
      .clk       (clk),
      .nRst      (nRst),
      .run       (run),
      .load_we   (load_we),
      .load_addr (load_addr),
      .load_data (load_data),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Outputs depend on registers only, so mid-cycle sampling is stable
   always @(negedge clk) begin
      if (nRst && out_valid) begin
         have_exp = 1'b0;
         exp_val  = 8'h00;
         if (exp_q.size() > 0) begin
            exp_val  = exp_q.pop_front();
            have_exp = 1'b1;
         end
         out_expected: assert (have_exp) else begin
            $display("Output 0x%02h at %0d ns was not expected", out_data, $time);
            test_errors++;
         end
         out_value: assert (!have_exp || out_data == exp_val) else begin
            $display("error at %0d ns: out_data 0x%02h, expected 0x%02h",
                     $time, out_data, exp_val);
            test_errors++;
         end
      end
   end

   initial begin
      cycle_count = 0;
      cycle_limit = 0;
      while (cycle_count <= cycle_limit) begin
         @(posedge clk);
         if (run)
            cycle_count++;
      end
      $display("Timeout: the program did not halt within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic apply_reset();
      @(negedge clk);
      nRst = 1'b0;
      run  = 1'b0;
      repeat (5) @(negedge clk);
      nRst = 1'b1;
   endtask

   task automatic load_image();
      for (int a = 0; a < 256; a++) begin
         @(negedge clk);
         load_we   = 1'b1;
         load_addr = 8'(a);
         load_data = image[a];
      end
      @(negedge clk);
      load_we = 1'b0;
   endtask

   task automatic run_test(input string name);
      int   n_exec;
      int   n_out;
      logic model_done;
      test_errors = 0;
      apply_reset();
      load_image();
      run_model(n_exec, model_done);
      n_out = exp_q.size();
      model_halts: assert (model_done) else begin
         $display("Program of test %s never reaches HALT", name);
         test_errors++;
      end
      cycle_limit += 5 * n_exec + 20;
      run = 1'b1;
      while (!halted)
         @(negedge clk);
      repeat (8) @(negedge clk);   // Window for stray outputs
      halt_held: assert (halted) else begin
         $display("halted dropped after HALT in test %s", name);
         test_errors++;
      end
      all_seen: assert (exp_q.size() == 0) else begin
         $display("Test %s: %0d expected outputs never appeared", name, exp_q.size());
         test_errors++;
      end
      apply_reset();
      halt_cleared: assert (!halted) else begin
         $display("halted still high after reset in test %s", name);
         test_errors++;
      end
      if (test_errors == 0) begin
         pass_count++;
         $display("Test %s passed, %0d instructions, %0d outputs", name, n_exec, n_out);
      end else begin
         fail_count++;
         $display("Test %s failed with %0d errors", name, test_errors);
      end
   endtask

   initial begin
      nRst       = 1'b0;
      run        = 1'b0;
      load_we    = 1'b0;
      load_addr  = 8'h00;
      load_data  = 8'h00;
      pass_count = 0;
      fail_count = 0;
      rnd        = $urandom(47185);
      clear_image();
      emit(OPC_OUT);   // sp ^ r3 right after reset
      emit(OPC_HALT);
      run_test("reset_out");
      build_alu();
      run_test("alu_ops");
      clear_image();
      emit(OPC_OUT);
      emit(OPC_SPINC);   // 0xFF wraps to 0x00
      emit(OPC_OUT);
      emit(OPC_SPDEC);   // And back to 0xFF
      emit(OPC_SPDEC);
      emit(OPC_OUT);
      emit(OPC_SPINC);
      emit(OPC_SPINC);
      emit(OPC_SPINC);
      emit(OPC_OUT);
      emit(OPC_HALT);
      run_test("sp_wrap");
      build_jmp();
      run_test("jmp_skip");
      clear_image();
      emit(OPC_OUT);
      emit(OPC_SPINC);
      emit(OPC_HALT);
      emit(OPC_OUT);   // Never reached
      emit(OPC_OUT);
      run_test("halt");
      $display("Tests run: %0d, passed: %0d, failed: %0d",
               pass_count + fail_count, pass_count, fail_count);
      if (fail_count == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+tb
hdl/up_pkg.sv
hdl/up_datapath.sv
hdl/up_control.sv
hdl/up_memory.sv
hdl/up_top.sv
tb/tb_up_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_up_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(wildcard hdl/*.sv tb/*.sv tb/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
